// File: design/efpga_consts.svh
`ifndef EFPGA_CONSTS_SVH
`define EFPGA_CONSTS_SVH

// lint bus widths
`define EFPGA_DATA_W      32
`define EFPGA_ADDR_W      20
`define EFPGA_BE_W        4

// fabric event lines toward the soc
`define EFPGA_N_EVENTS    16

// cycles from host req to gnt
`define EFPGA_HOLD_CYCLES 4

// fabric version word of 8 bits
`define EFPGA_VERSION     8'h11

// register word offsets on the lint port
`define EFPGA_REG_SCRATCH 'h0
`define EFPGA_REG_STATUS  'h4
`define EFPGA_REG_CONTROL 'h8
`define EFPGA_REG_VERSION 'hC

`endif

// File: design/efpga_event_bridge.sv
`timescale 1ns/1ps
`include "efpga_consts.svh"

module efpga_event_bridge import efpga_pkg::*; (
   input  logic       asic_clk_i,
   input  logic       rst_n,
   input  logic       enable_i,
   input  event_vec_t event_i,
   output event_vec_t event_o
);

   event_vec_t gated;
   event_vec_t sync1_q;
   event_vec_t sync2_q;
   event_vec_t hist_q;
   event_vec_t pulse_q;

   assign gated   = event_i & {`EFPGA_N_EVENTS{enable_i}};
   assign event_o = pulse_q;

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         sync1_q <= '0;
         sync2_q <= '0;
         hist_q  <= '0;
         pulse_q <= '0;
      end else begin
         sync1_q <= gated;               // first sync stage
         sync2_q <= sync1_q;
         hist_q  <= sync2_q;             // previous synced level
         pulse_q <= sync2_q & ~hist_q;   // rising edges only, one cycle wide
      end
   end

endmodule

// File: design/efpga_lint_if.sv
`timescale 1ns/1ps

interface efpga_lint_if import efpga_pkg::*; ();

   logic       req;
   lint_addr_t add;
   logic       wen;      // high means read
   lint_data_t wdata;
   lint_be_t   be;
   logic       gnt;
   logic       r_valid;
   lint_data_t r_rdata;

   modport master (
      output req,
      output add,
      output wen,
      output wdata,
      output be,
      input  gnt,
      input  r_valid,
      input  r_rdata
   );

   modport slave (
      input  req,
      input  add,
      input  wen,
      input  wdata,
      input  be,
      output gnt,
      output r_valid,
      output r_rdata
   );

endinterface

// File: design/efpga_lint_regs.sv
`timescale 1ns/1ps
`include "efpga_consts.svh"

module efpga_lint_regs import efpga_pkg::*; (
   input  logic        asic_clk_i,
   input  logic        rst_n,
   input  lint_data_t  control_i,
   output lint_data_t  status_o,
   efpga_lint_if.slave lint
);

   efpga_reg_e reg_sel;
   lint_data_t rd_data;
   lint_data_t scratch_q;
   lint_data_t status_q;
   logic       wr_en;
   logic       r_valid_q;
   lint_data_t r_rdata_q;

   function automatic lint_data_t be_merge(lint_data_t old_w, lint_data_t new_w, lint_be_t be);
      lint_data_t res;
      res = old_w;
      for (int b = 0; b < `EFPGA_BE_W; b++) begin
         if (be[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   always_comb begin
      case (lint.add)
         lint_addr_t'(`EFPGA_REG_SCRATCH): reg_sel = REG_SCRATCH;
         lint_addr_t'(`EFPGA_REG_STATUS):  reg_sel = REG_STATUS;
         lint_addr_t'(`EFPGA_REG_CONTROL): reg_sel = REG_CONTROL;
         lint_addr_t'(`EFPGA_REG_VERSION): reg_sel = REG_VERSION;
         default:                          reg_sel = REG_NONE;
      endcase
   end

   always_comb begin
      case (reg_sel)
         REG_SCRATCH: rd_data = scratch_q;
         REG_STATUS:  rd_data = status_q;
         REG_CONTROL: rd_data = control_i;
         REG_VERSION: rd_data = lint_data_t'(`EFPGA_VERSION);  // zero-extended
         default:     rd_data = '0;
      endcase
   end

   assign lint.gnt     = lint.req;  // never stalls
   assign wr_en        = lint.req & lint.gnt & ~lint.wen;
   assign lint.r_valid = r_valid_q;
   assign lint.r_rdata = r_rdata_q;
   assign status_o     = status_q;

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         scratch_q <= '0;
         status_q  <= '0;
         r_valid_q <= 1'b0;
      end else begin
         r_valid_q <= lint.req & lint.gnt;
         if (wr_en && reg_sel == REG_SCRATCH) begin
            scratch_q <= be_merge(scratch_q, lint.wdata, lint.be);
         end
         if (wr_en && reg_sel == REG_STATUS) begin
            status_q <= be_merge(status_q, lint.wdata, lint.be);
         end
      end
   end

   // writes answer with zero data
   always_ff @(posedge asic_clk_i) begin
      if (lint.req && lint.gnt) begin
         r_rdata_q <= lint.wen ? rd_data : '0;
      end
   end

endmodule

// File: design/efpga_lint_shaper.sv
`timescale 1ns/1ps
`include "efpga_consts.svh"

module efpga_lint_shaper import efpga_pkg::*; (
   input  logic         asic_clk_i,
   input  logic         rst_n,
   input  logic         enable_i,
   input  logic         req_i,
   input  lint_addr_t   add_i,
   input  logic         wen_i,
   input  lint_data_t   wdata_i,
   input  lint_be_t     be_i,
   output logic         gnt_o,
   output logic         r_valid_o,
   output lint_data_t   r_rdata_o,
   efpga_lint_if.master lint
);

   localparam int CNT_W = $clog2(`EFPGA_HOLD_CYCLES);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`EFPGA_HOLD_CYCLES - 1);

   lint_phase_e      phase_q;
   logic [CNT_W-1:0] hold_cnt_q;
   lint_data_t       rdata_q;

   // one bank access in the first cycle of the host request
   assign lint.req   = enable_i & req_i & (phase_q == IDLE);
   assign lint.add   = add_i;
   assign lint.wen   = wen_i;
   assign lint.wdata = wdata_i;
   assign lint.be    = be_i;

   // disabled port answers at once
   assign gnt_o     = enable_i ? (req_i & (phase_q == GRANT)) : req_i;
   assign r_valid_o = enable_i ? (phase_q == RESP) : 1'b1;
   assign r_rdata_o = enable_i ? rdata_q : '0;

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         phase_q    <= IDLE;
         hold_cnt_q <= '0;
      end else if (!enable_i) begin
         phase_q    <= IDLE;
         hold_cnt_q <= '0;
      end else begin
         case (phase_q)
            IDLE: begin
               if (lint.req && lint.gnt) begin
                  phase_q    <= HOLD;
                  hold_cnt_q <= CNT_W'(1);  // access edge counts as first
               end
            end
            HOLD: begin
               if (!req_i) begin
                  phase_q <= IDLE;  // host gave up
               end else if (hold_cnt_q == CNT_LAST) begin
                  phase_q <= GRANT;
               end else begin
                  hold_cnt_q <= hold_cnt_q + 1'b1;
               end
            end
            GRANT:   phase_q <= req_i ? RESP : IDLE;
            RESP:    phase_q <= IDLE;
            default: phase_q <= IDLE;
         endcase
      end
   end

   // bank response held until RESP
   always_ff @(posedge asic_clk_i) begin
      if (lint.r_valid) begin
         rdata_q <= lint.r_rdata;
      end
   end

endmodule

// File: design/efpga_pkg.sv
`include "efpga_consts.svh"

package efpga_pkg;

   typedef logic [`EFPGA_DATA_W-1:0]   lint_data_t;
   typedef logic [`EFPGA_ADDR_W-1:0]   lint_addr_t;
   typedef logic [`EFPGA_BE_W-1:0]     lint_be_t;
   typedef logic [`EFPGA_N_EVENTS-1:0] event_vec_t;

   // register decode of the lint address
   typedef enum logic [2:0] {
      REG_SCRATCH,
      REG_STATUS,
      REG_CONTROL,
      REG_VERSION,
      REG_NONE      // unmapped offset
   } efpga_reg_e;

   // shaper FSM
   typedef enum logic [1:0] {
      IDLE,
      HOLD,   // counting the hold-off
      GRANT,  // gnt toward host
      RESP    // r_valid toward host
   } lint_phase_e;

endpackage

// File: design/efpga_subsystem.sv
`timescale 1ns/1ps

module efpga_subsystem import efpga_pkg::*; (
   input  logic       asic_clk_i,
   input  logic       rst_n,
   input  logic       enable_apb_efpga_i,
   input  logic       enable_events_efpga_i,
   // host lint port, type 1
   input  logic       apbt1_req_i,
   input  lint_addr_t apbt1_add_i,
   input  logic       apbt1_wen_i,
   input  lint_data_t apbt1_wdata_i,
   input  lint_be_t   apbt1_be_i,
   output logic       apbt1_gnt_o,
   output logic       apbt1_r_valid_o,
   output lint_data_t apbt1_r_rdata_o,
   input  lint_data_t control_i,
   output lint_data_t status_o,
   input  event_vec_t fabric_event_i,
   output event_vec_t efpga_event_o
);

   efpga_lint_if lint_bus ();

   efpga_lint_shaper u_shaper (
      .asic_clk_i (asic_clk_i),
      .rst_n      (rst_n),
      .enable_i   (enable_apb_efpga_i),
      .req_i      (apbt1_req_i),
      .add_i      (apbt1_add_i),
      .wen_i      (apbt1_wen_i),
      .wdata_i    (apbt1_wdata_i),
      .be_i       (apbt1_be_i),
      .gnt_o      (apbt1_gnt_o),
      .r_valid_o  (apbt1_r_valid_o),
      .r_rdata_o  (apbt1_r_rdata_o),
      .lint       (lint_bus.master)
   );

   // stands in for the fabric register slice
   efpga_lint_regs u_regs (
      .asic_clk_i (asic_clk_i),
      .rst_n      (rst_n),
      .control_i  (control_i),
      .status_o   (status_o),
      .lint       (lint_bus.slave)
   );

   efpga_event_bridge u_events (
      .asic_clk_i (asic_clk_i),
      .rst_n      (rst_n),
      .enable_i   (enable_events_efpga_i),
      .event_i    (fabric_event_i),
      .event_o    (efpga_event_o)
   );

endmodule

// File: efpga_subsystem.f
+incdir+design
design/efpga_pkg.sv
design/efpga_lint_if.sv
design/efpga_lint_shaper.sv
design/efpga_lint_regs.sv
design/efpga_event_bridge.sv
design/efpga_subsystem.sv
tests/efpga_subsystem_asserts.sv
tests/efpga_subsystem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the efpga subsystem testbench with verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f efpga_subsystem.f \
   --top-module efpga_subsystem_tb -o efpga_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/efpga_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi
if grep -q "Test FAILED" "$log"; then
   exit 1
fi
exit 0

// File: tests/efpga_subsystem_asserts.sv
`timescale 1ns/1ps
`include "efpga_consts.svh"

module efpga_subsystem_asserts (
   input logic asic_clk_i,
   input logic rst_n,
   input logic enable_i,
   input logic req_i,
   input logic gnt_i,
   input logic r_valid_i,
   input logic lint_req_i
);

   // gnt only after req was held through the hold-off
   gnt_needs_req: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      enable_i && gnt_i |-> req_i && $past(req_i, `EFPGA_HOLD_CYCLES))
      else $error("gnt_o without req_i held through the hold-off");

   rvalid_after_gnt: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      enable_i && r_valid_i |-> $past(gnt_i))
      else $error("r_valid_o without a grant in the cycle before");

   rvalid_one_cycle: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      enable_i && r_valid_i |=> !(enable_i && r_valid_i))
      else $error("r_valid_o longer than one cycle");

   // single access toward the bank per host request
   fwd_req_one_cycle: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      lint_req_i |=> !lint_req_i)
      else $error("forwarded lint req longer than one cycle");

endmodule

bind efpga_lint_shaper efpga_subsystem_asserts u_asserts (
   .asic_clk_i (asic_clk_i),
   .rst_n      (rst_n),
   .enable_i   (enable_i),
   .req_i      (req_i),
   .gnt_i      (gnt_o),
   .r_valid_i  (r_valid_o),
   .lint_req_i (lint.req)
);

// File: tests/efpga_subsystem_tb.sv
`timescale 1ns/1ps
`include "efpga_consts.svh"

module efpga_subsystem_tb import efpga_pkg::*; ();

   localparam int TIMEOUT    = 40;  // cycles per wait
   localparam int EV_LATENCY = 3;   // two sync stages plus edge detect

   logic       asic_clk;
   logic       rst_n;
   logic       enable_apb;
   logic       enable_events;
   logic       apbt1_req;
   lint_addr_t apbt1_add;
   logic       apbt1_wen;
   lint_data_t apbt1_wdata;
   lint_be_t   apbt1_be;
   logic       apbt1_gnt;
   logic       apbt1_r_valid;
   lint_data_t apbt1_r_rdata;
   lint_data_t control;
   lint_data_t status;
   event_vec_t fabric_event;
   event_vec_t efpga_event;
   int         checks;
   int         errors;
   bit         aborted;

   efpga_subsystem DUT (
      .asic_clk_i            (asic_clk),
      .rst_n                 (rst_n),
      .enable_apb_efpga_i    (enable_apb),
      .enable_events_efpga_i (enable_events),
      .apbt1_req_i           (apbt1_req),
      .apbt1_add_i           (apbt1_add),
      .apbt1_wen_i           (apbt1_wen),
      .apbt1_wdata_i         (apbt1_wdata),
      .apbt1_be_i            (apbt1_be),
      .apbt1_gnt_o           (apbt1_gnt),
      .apbt1_r_valid_o       (apbt1_r_valid),
      .apbt1_r_rdata_o       (apbt1_r_rdata),
      .control_i             (control),
      .status_o              (status),
      .fabric_event_i        (fabric_event),
      .efpga_event_o         (efpga_event)
   );

   initial begin
      asic_clk = 1'b0;
      forever #4 asic_clk = ~asic_clk;
   end

   task automatic check_data(input string name, input lint_data_t got, input lint_data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_events(input string name, input event_vec_t got, input event_vec_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_cycles(input string name, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   // counts negedges until gnt or until r_valid when sel_rvalid is set
   task automatic wait_lint(input bit sel_rvalid, output int cycles);
      bit seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles <= TIMEOUT) begin
         @(negedge asic_clk);
         seen = sel_rvalid ? apbt1_r_valid : apbt1_gnt;
         if (!seen) cycles++;
      end
      if (!seen) begin
         errors++;
         aborted = 1'b1;
         $display("timeout, the DUT never raised %s", sel_rvalid ? "r_valid" : "gnt");
      end
   endtask

   task automatic lint_access(input bit is_read, input lint_addr_t addr, input lint_data_t data,
                              input lint_be_t be, output lint_data_t rdata);
      int gnt_cycles;
      int rsp_cycles;
      rdata = '0;
      @(posedge asic_clk);
      apbt1_req   <= 1'b1;
      apbt1_add   <= addr;
      apbt1_wen   <= is_read;
      apbt1_wdata <= data;
      apbt1_be    <= be;
      wait_lint(1'b0, gnt_cycles);
      if (aborted) return;
      check_cycles("gnt latency", gnt_cycles, enable_apb ? `EFPGA_HOLD_CYCLES : 0);
      @(posedge asic_clk);
      apbt1_req <= 1'b0;  // gnt seen on this edge
      wait_lint(1'b1, rsp_cycles);
      if (aborted) return;
      check_cycles("r_valid latency after gnt", rsp_cycles + 1, 1);
      rdata = apbt1_r_rdata;
   endtask

   task automatic event_step(input event_vec_t mask, input event_vec_t exp);
      int cycles;
      bit seen;
      @(posedge asic_clk);
      fabric_event <= mask;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles <= TIMEOUT) begin
         @(negedge asic_clk);
         seen = (efpga_event != '0);
         if (!seen) cycles++;
      end
      if (exp == '0) begin
         check_events("efpga_event_o", efpga_event, '0);  // quiet window
      end else if (!seen) begin
         errors++;
         aborted = 1'b1;
         $display("timeout, no event pulse for mask %h", mask);
      end else begin
         check_cycles("event latency", cycles, EV_LATENCY);
         check_events("efpga_event_o", efpga_event, exp);
         @(negedge asic_clk);
         check_events("efpga_event_o", efpga_event, '0);  // one cycle wide
      end
      @(posedge asic_clk);
      fabric_event <= '0;
      repeat (EV_LATENCY + 3) begin
         @(negedge asic_clk);
         check_events("efpga_event_o", efpga_event, '0);  // falling edge is silent
      end
   endtask

   initial begin
      int          fd;
      string       line;
      logic [7:0]  op;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      lint_data_t  rd;
      checks        = 0;
      errors        = 0;
      aborted       = 1'b0;
      rst_n         = 1'b0;
      enable_apb    = 1'b1;
      enable_events = 1'b1;
      apbt1_req     = 1'b0;
      apbt1_add     = '0;
      apbt1_wen     = 1'b1;
      apbt1_wdata   = '0;
      apbt1_be      = '0;
      control       = '0;
      fabric_event  = '0;
      repeat (4) @(posedge asic_clk);
      rst_n <= 1'b1;
      fd = $fopen("tests/efpga_subsystem_trace.txt", "r");
      if (fd == 0) begin
         errors++;
         aborted = 1'b1;
         $display("cannot open the trace file");
      end
      while (!aborted && $fgets(line, fd) > 0) begin
         if (line.len() < 2 || line.getc(0) == "#") continue;
         f1 = '0;
         f2 = '0;
         f3 = '0;
         void'($sscanf(line, "%c %h %h %h", op, f1, f2, f3));
         case (op)
            "W": begin
               lint_access(1'b0, lint_addr_t'(f1), f2, lint_be_t'(f3), rd);
               check_data("apbt1_r_rdata_o", rd, '0);  // writes answer zero
            end
            "R": begin
               lint_access(1'b1, lint_addr_t'(f1), '0, '1, rd);
               check_data("apbt1_r_rdata_o", rd, f2);
            end
            "C": begin
               @(posedge asic_clk);
               control <= f1;
            end
            "A": begin
               @(posedge asic_clk);
               enable_apb <= f1[0];
            end
            "V": begin
               @(posedge asic_clk);
               enable_events <= f1[0];
            end
            "E": event_step(event_vec_t'(f1), event_vec_t'(f2));
            "S": begin
               @(negedge asic_clk);
               check_data("status_o", status, f1);
            end
            default: begin
               errors++;
               $display("unknown trace operation in line: %s", line);
            end
         endcase
      end
      if (fd != 0) $fclose(fd);
      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: tests/efpga_subsystem_trace.txt
# W addr data be | R addr expected | C control | A port enable | V event enable
# E event mask expected pulses | S expected status, all fields hex
S 00000000
R 0 00000000
W 0 A5A5F00D F
R 0 A5A5F00D
W 0 12345678 5
R 0 A534F078
W 4 0000BEEF F
S 0000BEEF
C CAFE0001
R 8 CAFE0001
R C 00000011
R 10 00000000
A 0
W 0 FFFFFFFF F
R 0 00000000
A 1
R 0 A534F078
E 0005 0005
V 0
E 0100 0000
V 1
E 8000 8000
